// ==== src.f ====
logic/dbg_pkg.sv
logic/dbg_snapshot.sv
logic/dbg_byte_fifo.sv
logic/uart_tx.sv
logic/dbg_dump_top.sv
verification/tb_clkgen.sv
verification/dbg_uart_monitor.sv
verification/dbg_dump_props.sv
verification/dbg_dump_tb.sv

// ==== verification/dbg_dump_tb.sv ====
`timescale 1ns/100ps

module dbg_dump_tb;

  logic        clk, rst;
  logic        snap;
  logic [31:0] reg_data;
  logic [31:0] base_q;                       // Register model base of the current row
  logic [18:0] ctrl_q;                       // Control inputs, status byte order
  logic        branch_id, mem_read_id, mem_write_id, alu_src_id, reg_write_id;
  logic [1:0]  reg_dst_id, mem_to_reg_id, alu_op_id;
  logic        mem_read_ex, mem_write_ex, reg_write_ex;
  logic [1:0]  mem_to_reg_ex;
  logic        reg_write_mem;
  logic [1:0]  mem_to_reg_mem;
  logic [4:0]  reg_addr;
  logic        tx, busy;
  logic [dbg_pkg::dump_bytes*8-1:0] exp_img;
  int          rx_count, mismatch_errs, other_errs;
  int          tb_errs;
  integer      seed;

  // Stimulus table: register base, control word, second snap inside the dump
  logic [31:0] base_tab   [0:3];
  logic [18:0] ctrl_tab   [0:3];
  logic        resnap_tab [0:3];

  assign {reg_dst_id, mem_to_reg_id, alu_op_id,
          branch_id, mem_read_id, mem_write_id, alu_src_id, reg_write_id,
          mem_read_ex, mem_write_ex, reg_write_ex, mem_to_reg_ex,
          reg_write_mem, mem_to_reg_mem} = ctrl_q;

  // Register 0 reads as zero, others as base ^ (index * 0x01010101)
  function automatic logic [31:0] reg_model(input logic [31:0] base, input int idx);
    if (idx == 0)
      return 32'd0;
    return base ^ (idx * 32'h01010101);
  endfunction

  function automatic logic [dbg_pkg::dump_bytes*8-1:0] build_image(
    input logic [31:0] base, input logic [18:0] c);
    logic [dbg_pkg::dump_bytes*8-1:0] img;
    logic [31:0]                      word;
    img = '0;
    for (int r = 0; r < dbg_pkg::num_regs; r++)
    begin
      word = reg_model(base, r);
      for (int b = 0; b < 4; b++)
        img[8*(4*r+b) +: 8] = word[8*(3-b) +: 8];                 // MSB first
    end
    img[8*dbg_pkg::reg_bytes +: 8]       = {dbg_pkg::tag_ctrl2_id, c[18:17], c[16:15], c[14:13]};
    img[8*(dbg_pkg::reg_bytes+1) +: 8]   = {dbg_pkg::tag_ctrl1_id, c[12], c[11], c[10], c[9], c[8]};
    img[8*(dbg_pkg::reg_bytes+2) +: 8]   = {dbg_pkg::tag_ex, c[7], c[6], c[5], c[4:3]};
    img[8*(dbg_pkg::reg_bytes+3) +: 8]   = {dbg_pkg::tag_mem, c[2], c[1:0]};
    return img;
  endfunction

  assign reg_data = reg_model(base_q, reg_addr);   // Combinational spare read port

  tb_clkgen clkgen0 (.clk, .rst);

  dbg_dump_top dut0
  (
    .clk, .rst, .snap, .reg_data,
    .branch_id, .mem_read_id, .mem_write_id, .alu_src_id, .reg_write_id,
    .reg_dst_id, .mem_to_reg_id, .alu_op_id,
    .mem_read_ex, .mem_write_ex, .reg_write_ex, .mem_to_reg_ex,
    .reg_write_mem, .mem_to_reg_mem,
    .reg_addr, .tx, .busy
  );

  dbg_uart_monitor mon0
  (
    .clk, .rst, .snap, .tx, .busy, .exp_img, .rx_count, .mismatch_errs, .other_errs
  );

  ////////////////////
  // Apply loop
  ////////////////////
  initial
  begin
    int   cyc;
    int   busy_limit;
    logic timed_out;
    seed       = 45921;
    snap       = 1'b0;
    base_q     = 32'd0;
    ctrl_q     = 19'd0;
    exp_img    = '0;
    tb_errs    = 0;
    timed_out  = 1'b0;
    busy_limit = dbg_pkg::dump_bytes * 10 * dbg_pkg::clks_per_bit + 1000;  // Frames plus slack

    base_tab[0] = 32'h0000_0000;  ctrl_tab[0] = 19'h00000;  resnap_tab[0] = 1'b0;
    base_tab[1] = 32'hA5A5_5A5A;  ctrl_tab[1] = 19'h7FFFF;  resnap_tab[1] = 1'b1;
    base_tab[2] = 32'h1234_5678;  ctrl_tab[2] = 19'h2B6C9;  resnap_tab[2] = 1'b0;
    base_tab[3] = $random(seed);  ctrl_tab[3] = 19'($random(seed));  resnap_tab[3] = 1'b1;

    cyc = 0;
    while (rst && cyc < 20)
    begin
      @(posedge clk);
      cyc++;
    end
    if (rst)
    begin
      $display("Reset never released");
      tb_errs++;
    end
    repeat (20) @(posedge clk);    // Idle line checked by the monitor

    for (int i = 0; i < 4 && !timed_out; i++)
    begin
      @(posedge clk);
      #1;
      base_q  = base_tab[i];
      ctrl_q  = ctrl_tab[i];
      exp_img = build_image(base_tab[i], ctrl_tab[i]);
      snap    = 1'b1;
      @(posedge clk);
      #1;
      snap    = 1'b0;
      ctrl_q  = ~ctrl_tab[i];      // Pipeline moves on after the snap
      if (resnap_tab[i])
      begin
        repeat (50) @(posedge clk); // Still pushing register bytes
        #1;
        snap = 1'b1;
        @(posedge clk);
        #1;
        snap = 1'b0;
      end
      cyc = 0;
      while (busy && cyc < busy_limit)
      begin
        @(posedge clk);
        #1;
        cyc++;
      end
      if (busy)
      begin
        $display("Timeout: busy still high %0d cycles into row %0d", cyc, i);
        tb_errs++;
        timed_out = 1'b1;
      end
      else if (rx_count != dbg_pkg::dump_bytes)
      begin
        $display("Row %0d: received %0d bytes instead of %0d", i, rx_count,
                 dbg_pkg::dump_bytes);
        tb_errs++;
      end
    end

    $display("Error counts: mismatch=%0d monitor=%0d testbench=%0d assertion=%0d",
             mismatch_errs, other_errs, tb_errs, dut0.props0.assert_errs);
    if (mismatch_errs + other_errs + tb_errs + dut0.props0.assert_errs == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// ==== verification/dbg_dump_props.sv ====
`timescale 1ns/100ps

module dbg_dump_props
(
  input logic clk,
  input logic rst,
  input logic push,
  input logic full,
  input logic pop,
  input logic empty,
  input logic tx,
  input logic busy
);

  int assert_errs = 0;  // Assertion failures so far

  ////////////////////
  // FIFO flags
  ////////////////////
  flags_exclusive: assert property (@(posedge clk) disable iff (rst) !(full && empty))
    else
    begin
      $error("FIFO full and empty together");
      assert_errs++;
    end

  no_push_full: assert property (@(posedge clk) disable iff (rst) !(push && full))
    else
    begin
      $error("Push while FIFO full");
      assert_errs++;
    end

  no_pop_empty: assert property (@(posedge clk) disable iff (rst) !(pop && empty))
    else
    begin
      $error("Pop while FIFO empty");
      assert_errs++;
    end

  // A frame on the line always counts as busy
  busy_on_line: assert property (@(posedge clk) disable iff (rst) !tx |-> busy)
    else
    begin
      $error("tx low while busy is low");
      assert_errs++;
    end

endmodule

bind dbg_dump_top dbg_dump_props props0 (.clk, .rst, .push, .full, .pop, .empty, .tx, .busy);

// ==== verification/dbg_uart_monitor.sv ====
`timescale 1ns/100ps

module dbg_uart_monitor
(
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 snap,
  input  logic                                 tx,
  input  logic                                 busy,
  input  logic [dbg_pkg::dump_bytes*8-1:0]     exp_img,       // Byte k at bits [8k+7:8k]
  output int                                   rx_count,      // Bytes seen in this dump
  output int                                   mismatch_errs,
  output int                                   other_errs
);

  logic       in_frame;   // Start bit seen, stop bit not yet sampled
  logic       seen_snap;  // Line must idle until the first dump
  int         tick;       // Negedges since the start bit was seen
  int         bit_n;      // 0 start, 1 to 8 data, 9 stop
  int         stop_tail;  // Negedges since the last stop-bit sample
  logic [7:0] shift_r;    // Data bits, LSB arrives first
  logic [7:0] exp_byte;

  // Negedge sampling keeps clear of the posedge where tx moves
  always @(negedge clk)
  begin
    if (rst)
    begin
      in_frame      = 1'b0;
      seen_snap     = 1'b0;
      tick          = 0;
      stop_tail     = dbg_pkg::clks_per_bit;
      rx_count      = 0;
      mismatch_errs = 0;
      other_errs    = 0;
    end
    else
    begin
      if (!seen_snap && (tx !== 1'b1 || busy !== 1'b0))
      begin
        $display("Line not idle after reset: tx=%b busy=%b at %0t", tx, busy, $time);
        other_errs++;
      end
      if (snap && !busy)
      begin
        seen_snap = 1'b1;   // Accepted snap opens a new dump
        rx_count  = 0;
      end

      // Second half of the stop bit still counts as busy
      if (!in_frame && stop_tail < dbg_pkg::clks_per_bit)
      begin
        stop_tail++;
        if (stop_tail <= dbg_pkg::clks_per_bit - dbg_pkg::clks_per_bit / 2 && busy !== 1'b1)
        begin
          $display("Busy fell before the end of the stop bit at %0t", $time);
          other_errs++;
        end
      end

      ////////////////////
      // Frame decode
      ////////////////////
      if (!in_frame)
      begin
        if (tx === 1'b0)
        begin
          in_frame = 1'b1;  // Falling edge of the start bit
          tick     = 0;
        end
      end
      else
        tick++;

      // Half a bit in, the middle of each bit
      if (in_frame && (tick % dbg_pkg::clks_per_bit == dbg_pkg::clks_per_bit / 2 - 1))
      begin
        bit_n = tick / dbg_pkg::clks_per_bit;
        if (busy !== 1'b1)
        begin
          $display("Busy low in the middle of a frame at %0t", $time);
          other_errs++;
        end
        if (bit_n == 0)
        begin
          if (tx !== 1'b0)
          begin
            $display("Start bit not low at mid-bit at %0t", $time);
            other_errs++;
            in_frame = 1'b0;  // Glitch, hunt again
          end
        end
        else if (bit_n <= 8)
          shift_r = {tx, shift_r[7:1]};
        else
        begin
          if (tx !== 1'b1)
          begin
            $display("Stop bit not high for byte %0d at %0t", rx_count, $time);
            other_errs++;
          end
          if (rx_count >= dbg_pkg::dump_bytes)
          begin
            $display("Extra byte after the end of the dump: 0x%h", shift_r);
            other_errs++;
          end
          else
          begin
            exp_byte = exp_img[8*rx_count +: 8];
            if (shift_r !== exp_byte)
            begin
              $display("MISMATCH tx byte[%0d]: got 0x%h expected 0x%h",
                       rx_count, shift_r, exp_byte);
              mismatch_errs++;
            end
          end
          rx_count++;
          in_frame  = 1'b0;
          stop_tail = 0;
        end
      end
    end
  end

endmodule

// ==== verification/tb_clkgen.sv ====
`timescale 1ns/100ps

module tb_clkgen
(
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;     // 8 ns period
  end

  initial
  begin
    rst = 1'b1;
    repeat (5) @(posedge clk); // Five cycles of reset
    #1;
    rst = 1'b0;                // Released off the edge, like the stimulus
  end

endmodule

// ==== logic/dbg_dump_top.sv ====
`timescale 1ns/100ps

module dbg_dump_top
(
  input  logic        clk,
  input  logic        rst,
  input  logic        snap,
  input  logic [31:0] reg_data,
  // ID/EX controls
  input  logic        branch_id,
  input  logic        mem_read_id,
  input  logic        mem_write_id,
  input  logic        alu_src_id,
  input  logic        reg_write_id,
  input  logic [1:0]  reg_dst_id,
  input  logic [1:0]  mem_to_reg_id,
  input  logic [1:0]  alu_op_id,
  // EX/MEM controls
  input  logic        mem_read_ex,
  input  logic        mem_write_ex,
  input  logic        reg_write_ex,
  input  logic [1:0]  mem_to_reg_ex,
  // MEM/WB controls
  input  logic        reg_write_mem,
  input  logic [1:0]  mem_to_reg_mem,
  output logic [4:0]  reg_addr,       // Spare register file read port
  output logic        tx,             // UART line
  output logic        busy            // Dump still draining
);

  logic       push, full;            // Producer to buffer
  logic [7:0] push_data;
  logic       pop, empty;            // Buffer to line
  logic [7:0] pop_data;
  logic       active, tx_busy;

  dbg_snapshot snap0
  (
    .clk, .rst, .snap, .reg_data,
    .branch_id, .mem_read_id, .mem_write_id, .alu_src_id, .reg_write_id,
    .reg_dst_id, .mem_to_reg_id, .alu_op_id,
    .mem_read_ex, .mem_write_ex, .reg_write_ex, .mem_to_reg_ex,
    .reg_write_mem, .mem_to_reg_mem,
    .reg_addr, .push, .push_data, .full, .active
  );

  dbg_byte_fifo fifo0
  (
    .clk, .rst, .push, .push_data, .full, .pop, .pop_data, .empty
  );

  uart_tx tx0
  (
    .clk, .rst, .pop_data, .empty, .pop, .tx, .tx_busy
  );

  // Producing, buffered or on the line
  assign busy = active | ~empty | tx_busy;

endmodule

// ==== logic/uart_tx.sv ====
`timescale 1ns/100ps

module uart_tx
(
  input  logic       clk,
  input  logic       rst,
  input  logic [7:0] pop_data,   // FIFO head byte
  input  logic       empty,
  output logic       pop,        // Take the head byte this cycle
  output logic       tx,         // Serial line, idles high
  output logic       tx_busy     // Frame on the line
);

  enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_q;

  logic [$clog2(dbg_pkg::clks_per_bit)-1:0] bit_cnt_q;  // Cycles into the current bit
  logic [2:0]                               bit_idx_q;  // Data bit being sent
  logic [7:0]                               shift_q;    // LSB is on the line in st_data
  logic                                     bit_last;   // Final cycle of a bit

  assign bit_last = (bit_cnt_q == ($bits(bit_cnt_q))'(dbg_pkg::clks_per_bit - 1));

  // Pop when idle, or on the last stop cycle for back-to-back frames
  assign pop = ~empty & ((state_q == st_idle) | ((state_q == st_stop) & bit_last));

  ////////////////////
  // Frame FSM
  ////////////////////
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q   <= st_idle;
      bit_cnt_q <= '0;
      bit_idx_q <= 3'd0;
    end
    else
    begin
      if (state_q == st_idle || bit_last)
        bit_cnt_q <= '0;
      else
        bit_cnt_q <= bit_cnt_q + 1'b1;
      case (state_q)
        st_idle:
          if (pop)
            state_q <= st_start;           // Start bit on the next cycle
        st_start:
          if (bit_last)
          begin
            state_q   <= st_data;
            bit_idx_q <= 3'd0;
          end
        st_data:
          if (bit_last)
          begin
            bit_idx_q <= bit_idx_q + 3'd1;
            if (bit_idx_q == 3'd7)
              state_q <= st_stop;
          end
        default:                           // Stop bit
          if (bit_last)
            state_q <= pop ? st_start : st_idle;
      endcase
    end
  end

  // Data shift register
  always_ff @(posedge clk)
  begin
    if (pop)
      shift_q <= pop_data;                 // Load on the pop edge
    else if (state_q == st_data && bit_last)
      shift_q <= {1'b0, shift_q[7:1]};     // LSB first
  end

  assign tx = (state_q == st_start) ? 1'b0 :
              (state_q == st_data)  ? shift_q[0] : 1'b1;

  assign tx_busy = (state_q != st_idle);

endmodule

// ==== logic/dbg_byte_fifo.sv ====
`timescale 1ns/100ps

module dbg_byte_fifo
(
  input  logic       clk,
  input  logic       rst,
  input  logic       push,       // Write request
  input  logic [7:0] push_data,
  output logic       full,
  input  logic       pop,        // Read request
  output logic [7:0] pop_data,   // Head entry
  output logic       empty
);

  logic [7:0]                  mem [0:dbg_pkg::fifo_depth-1];
  logic [dbg_pkg::fifo_aw-1:0] wr_ptr_q, wr_ptr_next, wr_ptr_succ;
  logic [dbg_pkg::fifo_aw-1:0] rd_ptr_q, rd_ptr_next, rd_ptr_succ;
  logic                        full_q, full_next;
  logic                        empty_q, empty_next;
  logic                        wr_en;                 // Legal push
  logic                        rd_en;                 // Legal pop

  assign wr_en = push & ~full_q;   // Push while full is dropped
  assign rd_en = pop & ~empty_q;   // Pop while empty is dropped

  ////////////////////
  // Storage
  ////////////////////
  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr_ptr_q] <= push_data;
  end

  assign pop_data = mem[rd_ptr_q];

  ////////////////////
  // Pointers and flags
  ////////////////////
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      full_q   <= 1'b0;
      empty_q  <= 1'b1;
    end
    else
    begin
      wr_ptr_q <= wr_ptr_next;
      rd_ptr_q <= rd_ptr_next;
      full_q   <= full_next;
      empty_q  <= empty_next;
    end
  end

  assign wr_ptr_succ = wr_ptr_q + 1'b1;  // Wraps at fifo_depth
  assign rd_ptr_succ = rd_ptr_q + 1'b1;

  always_comb
  begin
    wr_ptr_next = wr_ptr_q;
    rd_ptr_next = rd_ptr_q;
    full_next   = full_q;
    empty_next  = empty_q;
    case ({wr_en, rd_en})
      2'b01:                                  // Pop only
      begin
        rd_ptr_next = rd_ptr_succ;
        full_next   = 1'b0;
        if (rd_ptr_succ == wr_ptr_q)
          empty_next = 1'b1;                  // Last entry leaves
      end
      2'b10:                                  // Push only
      begin
        wr_ptr_next = wr_ptr_succ;
        empty_next  = 1'b0;
        if (wr_ptr_succ == rd_ptr_q)
          full_next = 1'b1;                   // Writer caught the reader
      end
      2'b11:                                  // Both, occupancy unchanged
      begin
        wr_ptr_next = wr_ptr_succ;
        rd_ptr_next = rd_ptr_succ;
      end
      default: ;                              // Idle
    endcase
  end

  assign full  = full_q;
  assign empty = empty_q;

endmodule

// ==== logic/dbg_snapshot.sv ====
`timescale 1ns/100ps

module dbg_snapshot
(
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   snap,           // One-cycle dump request
  input  logic [31:0]                            reg_data,       // Spare read port data
  // ID/EX controls
  input  logic                                   branch_id,
  input  logic                                   mem_read_id,
  input  logic                                   mem_write_id,
  input  logic                                   alu_src_id,
  input  logic                                   reg_write_id,
  input  logic [1:0]                             reg_dst_id,
  input  logic [1:0]                             mem_to_reg_id,
  input  logic [1:0]                             alu_op_id,
  // EX/MEM controls
  input  logic                                   mem_read_ex,
  input  logic                                   mem_write_ex,
  input  logic                                   reg_write_ex,
  input  logic [1:0]                             mem_to_reg_ex,
  // MEM/WB controls
  input  logic                                   reg_write_mem,
  input  logic [1:0]                             mem_to_reg_mem,
  output logic [$clog2(dbg_pkg::num_regs)-1:0]   reg_addr,       // Spare read port address
  output logic                                   push,           // Byte valid toward the FIFO
  output logic [7:0]                             push_data,
  input  logic                                   full,           // FIFO back-pressure
  output logic                                   active          // Dump in progress
);

  logic        running_q;   // Producer is walking the dump
  logic [7:0]  cnt_q;       // Byte index 0 to 131
  logic [18:0] ctrl_q;      // Control inputs frozen at the snap
  logic        reg_phase;   // Index still inside the register bytes
  logic        last_byte;   // Index on the final status byte
  logic        advance;     // Byte accepted this cycle
  logic [31:0] status_word; // Four tagged status bytes, byte 128 on top
  logic [31:0] src_word;    // Word the current byte is cut from

  ////////////////////
  // Sequencing
  ////////////////////
  assign advance   = running_q & ~full;                      // Hold the byte while full
  assign last_byte = (cnt_q == 8'(dbg_pkg::dump_bytes - 1));

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      running_q <= 1'b0;
      cnt_q     <= 8'd0;
    end
    else if (!running_q)
    begin
      if (snap)
      begin
        running_q <= 1'b1;                                   // First push on the next cycle
        cnt_q     <= 8'd0;
      end
    end
    else if (advance)
    begin
      if (last_byte)
      begin
        running_q <= 1'b0;                                   // Dump complete
        cnt_q     <= 8'd0;
      end
      else
        cnt_q <= cnt_q + 8'd1;
    end
  end

  // Freeze the pipeline controls; a snap during a dump is ignored
  always_ff @(posedge clk)
  begin
    if (snap && !running_q)
      ctrl_q <= {reg_dst_id, mem_to_reg_id, alu_op_id,                    // [18:13]
                 branch_id, mem_read_id, mem_write_id, alu_src_id,        // [12:9]
                 reg_write_id,                                            // [8]
                 mem_read_ex, mem_write_ex, reg_write_ex, mem_to_reg_ex,  // [7:3]
                 reg_write_mem, mem_to_reg_mem};                          // [2:0]
  end

  ////////////////////
  // Byte selection
  ////////////////////
  assign reg_phase = (cnt_q < 8'(dbg_pkg::reg_bytes));
  assign reg_addr  = cnt_q[2 +: $clog2(dbg_pkg::num_regs)]; // Index divided by four

  assign status_word = {dbg_pkg::tag_ctrl2_id, ctrl_q[18:13],  // Byte 128
                        dbg_pkg::tag_ctrl1_id, ctrl_q[12:8],   // Byte 129
                        dbg_pkg::tag_ex,       ctrl_q[7:3],    // Byte 130
                        dbg_pkg::tag_mem,      ctrl_q[2:0]};   // Byte 131

  assign src_word = reg_phase ? reg_data : status_word;

  // Most significant byte of each word goes first
  always_comb
  begin
    case (cnt_q[1:0])
      2'd0:    push_data = src_word[31:24];
      2'd1:    push_data = src_word[23:16];
      2'd2:    push_data = src_word[15:8];
      default: push_data = src_word[7:0];
    endcase
  end

  assign push   = running_q;  // One byte offered per cycle
  assign active = running_q;

endmodule

// ==== logic/dbg_pkg.sv ====
package dbg_pkg;

  ////////////////////
  // Dump layout
  ////////////////////
  localparam int num_regs   = 32;  // General registers in the file
  localparam int reg_bytes  = 128; // Four bytes per register
  localparam int dump_bytes = 132; // Register bytes plus four status bytes

  ////////////////////
  // Status byte tags
  ////////////////////
  localparam logic [1:0] tag_ctrl2_id = 2'b00;    // Byte 128, two-bit ID/EX controls
  localparam logic [2:0] tag_ctrl1_id = 3'b101;   // Byte 129, one-bit ID/EX controls
  localparam logic [2:0] tag_ex       = 3'b010;   // Byte 130, EX/MEM controls
  localparam logic [4:0] tag_mem      = 5'b00110; // Byte 131, MEM/WB controls

  ////////////////////
  // Buffer and line
  ////////////////////
  localparam int fifo_depth   = 256; // Deeper than one dump, so a dump never stalls
  localparam int fifo_aw      = 8;   // Pointer width, wraps at fifo_depth
  localparam int clks_per_bit = 16;  // UART bit time in clk cycles

endpackage
